// File: hdl/gpr_pkg.sv
/*
 * gpr package
 * register widths, architectural indices, operand size codes and
 * the bank type shared by the register file blocks
 */
`default_nettype none

package gpr_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int GPR_W   = 32;
    localparam int NUM_GPR = 8;

    typedef logic [GPR_W-1:0] gpr_word_t;

    // architectural order: eax ecx edx ebx esp ebp esi edi
    typedef logic [2:0] gpr_idx_t;

    // operand size code, 3 is not a legal size
    typedef enum logic [1:0] {
        SIZE_32   = 2'd0,
        SIZE_16   = 2'd1,
        SIZE_8    = 2'd2,
        SIZE_NONE = 2'd3
    } opsize_e;

    // whole architectural state, word i is register i
    typedef logic [NUM_GPR-1:0][GPR_W-1:0] gpr_bank_t;

    // ------------------------------------------------------------------
    // registers with dedicated load paths
    // ------------------------------------------------------------------
    localparam gpr_idx_t IDX_ESP = 3'd4;
    localparam gpr_idx_t IDX_ESI = 3'd6;
    localparam gpr_idx_t IDX_EDI = 3'd7;

endpackage

`default_nettype wire

// File: hdl/gpr_update_if.sv
/*
 * register update interface
 * per-register load enables and load words from the write merge
 * stage to the register bank
 */
`timescale 1ns/100ps
`default_nettype none

interface gpr_update_if;

    import gpr_pkg::*;

    // one enable per architectural register
    logic [NUM_GPR-1:0] load_en;

    // word i is only meaningful while load_en[i] is high
    gpr_bank_t load_data;

    // merge stage drives the requests
    modport source (
        output load_en,
        output load_data
    );

    // bank takes every request, no back-pressure
    modport sink (
        input load_en,
        input load_data
    );

endinterface

`default_nettype wire

// File: hdl/gpr_write_merge.sv
/*
 * write merge stage
 * turns the sized writeback, the esi/edi string loads and the esp
 * stack write into one load request per register
 */
`timescale 1ns/100ps
`default_nettype none

module gpr_write_merge (
    input  wire gpr_pkg::gpr_idx_t  writeback_reg,
    input  wire                     writeback_en,
    input  wire gpr_pkg::opsize_e   writeback_size,
    input  wire gpr_pkg::gpr_word_t writeback_data,
    input  wire gpr_pkg::gpr_word_t esi_data,
    input  wire                     esi_en,
    input  wire gpr_pkg::gpr_word_t edi_data,
    input  wire                     edi_en,
    input  wire gpr_pkg::gpr_word_t write_esp,
    input  wire                     write_esp_enable,
    input  wire gpr_pkg::gpr_bank_t regs,
    gpr_update_if.source            upd
);

    import gpr_pkg::*;

    gpr_idx_t           wb_target;
    logic               wb_high_byte;
    logic               wb_valid;
    gpr_word_t          wb_word;
    logic [NUM_GPR-1:0] wb_load;

    // ------------------------------------------------------------------
    // writeback target
    // ------------------------------------------------------------------
    // 8-bit index 4..7 folds onto ah/ch/dh/bh of registers 0..3
    always_comb begin
        wb_target    = writeback_reg;
        wb_high_byte = 1'b0;
        wb_valid     = writeback_en;
        if (writeback_size == SIZE_8) begin
            wb_target    = {1'b0, writeback_reg[1:0]};
            wb_high_byte = writeback_reg[2];
        end else if (writeback_size == SIZE_NONE) begin
            wb_valid = 1'b0;
        end
    end

    // merge new data into the untouched bytes of the target
    always_comb begin
        wb_word = regs[wb_target];
        case (writeback_size)
            SIZE_32: wb_word = writeback_data;
            SIZE_16: wb_word[15:0] = writeback_data[15:0];
            SIZE_8: begin
                if (wb_high_byte) begin
                    wb_word[15:8] = writeback_data[7:0];
                end else begin
                    wb_word[7:0] = writeback_data[7:0];
                end
            end
            default: wb_word = regs[wb_target];
        endcase
    end

    // one-hot decode of the writeback target
    always_comb begin
        for (int i = 0; i < NUM_GPR; i++) begin
            wb_load[i] = wb_valid && (wb_target == gpr_idx_t'(i));
        end
    end

    // ------------------------------------------------------------------
    // priority between load sources
    // ------------------------------------------------------------------
    always_comb begin
        upd.load_en = wb_load;
        for (int i = 0; i < NUM_GPR; i++) begin
            upd.load_data[i] = wb_word;
        end

        // stack write loads esp unless writeback targets it too
        upd.load_en[IDX_ESP] = wb_load[IDX_ESP] | write_esp_enable;
        if (!wb_load[IDX_ESP]) begin
            upd.load_data[IDX_ESP] = write_esp;
        end

        // string loads win over writeback, each on its own enable
        if (esi_en) begin
            upd.load_en[IDX_ESI]   = 1'b1;
            upd.load_data[IDX_ESI] = esi_data;
        end
        if (edi_en) begin
            upd.load_en[IDX_EDI]   = 1'b1;
            upd.load_data[IDX_EDI] = edi_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/gpr_bank.sv
/*
 * register bank
 * the eight architectural registers, cleared by reset and loaded
 * one word at a time from the update interface
 */
`timescale 1ns/100ps
`default_nettype none

module gpr_bank (
    input  wire                     clk,
    input  wire                     rst_n,
    gpr_update_if.sink              upd,
    output gpr_pkg::gpr_bank_t      regs
);

    import gpr_pkg::*;

    // ------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------
    // asynchronous clear, then one load per enabled register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            for (int i = 0; i < NUM_GPR; i++) begin
                // each register has its own enable
                if (upd.load_en[i]) begin
                    regs[i] <= upd.load_data[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/gpr_read_port.sv
/*
 * operand read port
 * combinational sized read of one register with x86 byte aliasing,
 * result zero-extended to the full word
 */
`timescale 1ns/100ps
`default_nettype none

module gpr_read_port (
    input  wire gpr_pkg::gpr_idx_t  sel,
    input  wire gpr_pkg::opsize_e   size,
    input  wire gpr_pkg::gpr_bank_t regs,
    output gpr_pkg::gpr_word_t      value
);

    import gpr_pkg::*;

    gpr_idx_t  byte_reg;
    gpr_word_t full_word;
    gpr_word_t byte_word;

    // 8-bit index 4..7 maps to bits 15:8 of registers 0..3
    assign byte_reg  = {1'b0, sel[1:0]};
    assign full_word = regs[sel];
    assign byte_word = regs[byte_reg];

    always_comb begin
        case (size)
            SIZE_32: value = full_word;
            SIZE_16: value = GPR_W'(full_word[15:0]);
            SIZE_8: begin
                if (sel[2]) begin
                    value = GPR_W'(byte_word[15:8]);
                end else begin
                    value = GPR_W'(byte_word[7:0]);
                end
            end
            // size code 3 reads as zero
            default: value = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/gpr_file_top.sv
/*
 * general-purpose register file
 * write merge stage and register bank with two sized operand
 * read ports, one clock write latency and no read bypass
 */
`timescale 1ns/100ps
`default_nettype none

module gpr_file_top (
    input  wire                     clk,
    input  wire                     rst_n,

    // operand reads
    input  wire gpr_pkg::opsize_e   register_size,
    input  wire gpr_pkg::gpr_idx_t  op_1,
    output gpr_pkg::gpr_word_t      op_1_value,
    input  wire gpr_pkg::gpr_idx_t  op_2,
    output gpr_pkg::gpr_word_t      op_2_value,

    // writeback
    input  wire gpr_pkg::gpr_idx_t  writeback_reg,
    input  wire                     writeback_en,
    input  wire gpr_pkg::opsize_e   writeback_size,
    input  wire gpr_pkg::gpr_word_t writeback_data,

    // string moves and stack
    input  wire gpr_pkg::gpr_word_t esi_data,
    input  wire                     esi_en,
    input  wire gpr_pkg::gpr_word_t edi_data,
    input  wire                     edi_en,
    input  wire gpr_pkg::gpr_word_t write_esp,
    input  wire                     write_esp_enable
);

    import gpr_pkg::*;

    gpr_bank_t regs;

    gpr_update_if upd_if ();

    // ------------------------------------------------------------------
    // write path
    // ------------------------------------------------------------------
    gpr_write_merge u_merge (
        .writeback_reg    (writeback_reg),
        .writeback_en     (writeback_en),
        .writeback_size   (writeback_size),
        .writeback_data   (writeback_data),
        .esi_data         (esi_data),
        .esi_en           (esi_en),
        .edi_data         (edi_data),
        .edi_en           (edi_en),
        .write_esp        (write_esp),
        .write_esp_enable (write_esp_enable),
        .regs             (regs),
        .upd              (upd_if.source)
    );

    gpr_bank u_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .upd   (upd_if.sink),
        .regs  (regs)
    );

    // ------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------
    // both operands share one size
    gpr_read_port u_rd1 (
        .sel   (op_1),
        .size  (register_size),
        .regs  (regs),
        .value (op_1_value)
    );

    gpr_read_port u_rd2 (
        .sel   (op_2),
        .size  (register_size),
        .regs  (regs),
        .value (op_2_value)
    );

endmodule

`default_nettype wire

// File: verification/gpr_file_tb.sv
/*
 * register file testbench
 * drives gpr_file_top with directed and LFSR stimulus and checks both
 * operand ports against a shadow model every cycle
 */
`timescale 1ns/100ps
`default_nettype none

module gpr_file_tb;

    import gpr_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam logic [31:0] LFSR_SEED = 32'd77633;
    localparam int N_SWEEP  = 32;
    localparam int N_FULL   = 16;
    localparam int N_SIZED  = 24;
    localparam int N_PRIO   = 8;
    localparam int N_NONE   = 16;
    localparam int N_RANDOM = 400;
    // every test ends with one idle cycle, plus some slack
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_SWEEP + N_FULL + N_SIZED
                                   + N_PRIO + N_NONE + N_RANDOM + 6 + 50;

    typedef logic [7:0][GPR_W-1:0] state_t;

    logic             clk, rst_n;
    opsize_e          register_size, writeback_size;
    logic [2:0]       op_1, op_2, writeback_reg;
    logic [GPR_W-1:0] op_1_value, op_2_value, writeback_data;
    logic [GPR_W-1:0] esi_data, edi_data, write_esp;
    logic             writeback_en, esi_en, edi_en, write_esp_enable;

    state_t      shadow;
    logic [31:0] lfsr_state;
    int          checks, errors, err_base, test_num, tests_passed, tests_failed;

    gpr_file_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------------
    // right-shifting galois LFSR, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic state_t next_state(input state_t cur, input logic [2:0] wb_reg,
                                          input logic wb_en, input opsize_e wb_size,
                                          input logic [GPR_W-1:0] wb_data);
        state_t           nxt;
        logic [2:0]       tgt;
        logic [GPR_W-1:0] word;
        nxt = cur;
        // stack write first, a writeback to esp replaces it
        if (write_esp_enable) begin
            nxt[4] = write_esp;
        end
        if (wb_en && wb_size != SIZE_NONE) begin
            tgt  = (wb_size == SIZE_8) ? {1'b0, wb_reg[1:0]} : wb_reg;
            word = cur[tgt];
            case (wb_size)
                SIZE_32: word = wb_data;
                SIZE_16: word[15:0] = wb_data[15:0];
                default: begin
                    if (wb_reg[2]) begin
                        word[15:8] = wb_data[7:0];
                    end else begin
                        word[7:0] = wb_data[7:0];
                    end
                end
            endcase
            nxt[tgt] = word;
        end
        // string loads have the last word on esi and edi
        if (esi_en) begin
            nxt[6] = esi_data;
        end
        if (edi_en) begin
            nxt[7] = edi_data;
        end
        return nxt;
    endfunction

    function automatic logic [GPR_W-1:0] read_ref(input state_t st, input logic [2:0] idx,
                                                  input opsize_e size);
        logic [GPR_W-1:0] low_reg;
        low_reg = st[{1'b0, idx[1:0]}];
        case (size)
            SIZE_32: return st[idx];
            SIZE_16: return {16'h0, st[idx][15:0]};
            SIZE_8:  return idx[2] ? {24'h0, low_reg[15:8]} : {24'h0, low_reg[7:0]};
            default: return '0;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------------
    task automatic check_port(input string name, input logic [GPR_W-1:0] exp,
                              input logic [GPR_W-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s expected %08h actual %08h at %0t", name, exp, got, $time);
            errors++;
        end
    endtask

    // inputs still hold last cycle's values at the edge
    always @(posedge clk) begin
        if (!rst_n) begin
            shadow = '0;
        end else begin
            shadow = next_state(shadow, writeback_reg, writeback_en, writeback_size,
                                writeback_data);
        end
        #2;
        check_port("op_1_value", read_ref(shadow, op_1, register_size), op_1_value);
        check_port("op_2_value", read_ref(shadow, op_2, register_size), op_2_value);
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic idle_writes();
        writeback_en     <= 1'b0;
        esi_en           <= 1'b0;
        edi_en           <= 1'b0;
        write_esp_enable <= 1'b0;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        idle_writes();
        #5;
        test_num++;
        if (errors == err_base) begin
            tests_passed++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", test_num, name, errors - err_base);
        end
        err_base = errors;
    endtask

    task automatic reset_sweep();
        for (int k = 0; k < RESET_CYCLES + N_SWEEP; k++) begin
            @(posedge clk);
            op_1          <= 3'(k);
            op_2          <= 3'(7 - k);
            register_size <= opsize_e'(2'(k >> 3));
            // writes while in reset must not land
            writeback_en   <= (k < RESET_CYCLES - 1);
            writeback_reg  <= 3'(k);
            writeback_size <= SIZE_32;
            writeback_data <= take_bits(32);
            if (k == RESET_CYCLES - 1) begin
                rst_n <= 1'b1;
            end
        end
    endtask

    task automatic full_writes();
        for (int k = 0; k < N_FULL; k++) begin
            @(posedge clk);
            writeback_en   <= (k < 8);
            writeback_reg  <= 3'(k);
            writeback_size <= SIZE_32;
            writeback_data <= take_bits(32);
            register_size  <= SIZE_32;
            op_1           <= 3'(k + 7);
            op_2           <= 3'(k + 3);
        end
    endtask

    task automatic sized_writes();
        for (int k = 0; k < N_SIZED; k++) begin
            @(posedge clk);
            writeback_en   <= 1'b1;
            writeback_reg  <= 3'(k);
            writeback_size <= (k < 8) ? SIZE_16 : SIZE_8;
            writeback_data <= take_bits(32);
            register_size  <= opsize_e'(2'(k % 3));
            op_1           <= 3'(k + 7);
            op_2           <= 3'(k + 3);
        end
    endtask

    task automatic load_priority();
        for (int k = 0; k < N_PRIO; k++) begin
            @(posedge clk);
            idle_writes();
            writeback_size <= SIZE_32;
            writeback_data <= take_bits(32);
            esi_data       <= take_bits(32);
            edi_data       <= take_bits(32);
            write_esp      <= take_bits(32);
            register_size  <= SIZE_32;
            op_1           <= 3'd4;
            op_2           <= (k == 1) ? 3'd6 : 3'd7;
            case (k)
                0: begin
                    writeback_en  <= 1'b1;
                    writeback_reg <= 3'd6;
                    esi_en        <= 1'b1;
                end
                2: begin
                    writeback_en   <= 1'b1;
                    writeback_reg  <= 3'd7;
                    writeback_size <= SIZE_16;
                    edi_en         <= 1'b1;
                end
                4: write_esp_enable <= 1'b1;
                6: begin
                    writeback_en     <= 1'b1;
                    writeback_reg    <= 3'd4;
                    write_esp_enable <= 1'b1;
                end
                default: ;
            endcase
        end
    endtask

    task automatic size_none();
        for (int k = 0; k < N_NONE; k++) begin
            @(posedge clk);
            writeback_en   <= 1'b1;
            writeback_reg  <= 3'(k);
            writeback_size <= SIZE_NONE;
            writeback_data <= take_bits(32);
            register_size  <= (k % 2 == 1) ? SIZE_NONE : SIZE_32;
            // full-size cycles read one even and one odd register
            op_1           <= 3'(k);
            op_2           <= 3'(k + 5);
        end
    endtask

    task automatic random_mix();
        for (int k = 0; k < N_RANDOM; k++) begin
            @(posedge clk);
            writeback_reg    <= 3'(take_bits(3));
            writeback_en     <= 1'(take_bits(1));
            writeback_size   <= opsize_e'(2'(take_bits(2)));
            writeback_data   <= take_bits(32);
            esi_en           <= (take_bits(2) == 0);
            esi_data         <= take_bits(32);
            edi_en           <= (take_bits(2) == 0);
            edi_data         <= take_bits(32);
            write_esp_enable <= (take_bits(2) == 0);
            write_esp        <= take_bits(32);
            register_size    <= opsize_e'(2'(take_bits(2)));
            op_1             <= 3'(take_bits(3));
            op_2             <= 3'(take_bits(3));
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        register_size = SIZE_32;
        op_1 = '0;
        op_2 = '0;
        writeback_reg = '0;
        writeback_en = 1'b0;
        writeback_size = SIZE_32;
        writeback_data = '0;
        esi_data = '0;
        esi_en = 1'b0;
        edi_data = '0;
        edi_en = 1'b0;
        write_esp = '0;
        write_esp_enable = 1'b0;
        shadow = '0;
        lfsr_state = LFSR_SEED;
        checks = 0;
        errors = 0;
        err_base = 0;
        test_num = 0;
        tests_passed = 0;
        tests_failed = 0;

        reset_sweep();
        end_test("reset and zero reads");
        full_writes();
        end_test("32-bit writes");
        sized_writes();
        end_test("16-bit and 8-bit writes");
        load_priority();
        end_test("string and stack load priority");
        size_none();
        end_test("size code 3");
        random_mix();
        end_test("random mix");

        $display("tests passed %0d failed %0d, %0d checks, %0d mismatches",
                 tests_passed, tests_failed, checks, errors);
        if (tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("error: simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: gpr_file_top.f
hdl/gpr_pkg.sv
hdl/gpr_update_if.sv
hdl/gpr_write_merge.sv
hdl/gpr_bank.sv
hdl/gpr_read_port.sv
hdl/gpr_file_top.sv
verification/gpr_file_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the register file testbench with verilator, run it into a log
# and decide pass or fail from the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module gpr_file_tb \
    -f gpr_file_top.f \
    --Mdir "$BUILD_DIR" -o gpr_file_sim

"./$BUILD_DIR/gpr_file_sim" | tee "$LOG_FILE"

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi
